// File: compile.f
hw/de_pkg.sv
hw/instr_decoder.sv
hw/reg_scoreboard.sv
hw/de_latch_stage.sv
hw/decode_stage.sv
dv/decode_stage_assert.sv
dv/decode_checker.sv
dv/decode_stage_tb.sv

// File: run_sim.sh
#!/bin/bash
# build and run the decode stage testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -f compile.f --top-module decode_stage_tb \
  -o sim_decode_stage \
  && ./obj_dir/sim_decode_stage > sim.log 2>&1
cat sim.log 2>/dev/null

grep -q "^Simulation passed$" sim.log && exit 0 || exit 1

// File: dv/decode_stage_tb.sv
`default_nettype none

module decode_stage_tb;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int STALL_LIMIT = 60;  // cycles an instruction may wait
  localparam int DRAIN_LIMIT = 100;

  logic              clk;
  logic              reset;
  de_pkg::fe_latch_t fe_latch;
  de_pkg::wb_write_t wb;
  logic              br_mispred;
  logic              stall;
  de_pkg::de_latch_t de_out;

  logic       last_stall = 1'b0;  // stall seen at the last rising edge
  logic [4:0] pend_reg[$];        // reserved destinations, oldest first
  int         pend_due[$];
  int         cycle       = 0;
  int         mispred_pct = 0;
  logic [31:0] pc         = 32'h0000_1000;

  decode_stage i_decode_stage (
    .clk        (clk),
    .reset      (reset),
    .fe_latch   (fe_latch),
    .wb         (wb),
    .br_mispred (br_mispred),
    .stall      (stall),
    .de_out     (de_out)
  );

  decode_checker i_checker (
    .clk        (clk),
    .reset      (reset),
    .fe_latch   (fe_latch),
    .wb         (wb),
    .br_mispred (br_mispred),
    .stall      (stall),
    .de_out     (de_out)
  );

  bind de_latch_stage decode_stage_assert i_decode_stage_assert (
    .clk    (clk),
    .reset  (reset),
    .stall  (stall),
    .issue  (issue),
    .valid  (fe_latch.valid),
    .de_out (de_out)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(posedge clk) last_stall <= stall;

  //////////////////////////////////////////////////
  // stimulus helpers
  //////////////////////////////////////////////////

  function automatic logic [31:0] random_inst(input int span);
    logic [31:0] r;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [6:0]  f7;
    r   = $urandom;
    rd  = 5'($urandom % span);
    rs1 = 5'($urandom % span);
    rs2 = 5'($urandom % span);
    f7  = r[25] ? de_pkg::F7_SUB_SRA : (r[26] ? de_pkg::F7_MUL : de_pkg::F7_ZERO);
    case ($urandom % 12)
      0:  return {f7, rs2, rs1, r[14:12], rd, de_pkg::OPC_OP};
      1:  return {r[31:20], rs1, r[14:12], rd, de_pkg::OPC_OP_IMM};
      2:  return {f7, r[24:20], rs1, r[12], 2'b01, rd, de_pkg::OPC_OP_IMM};  // shifts
      3:  return {r[31:12], rd, de_pkg::OPC_LUI};
      4:  return {r[31:12], rd, de_pkg::OPC_AUIPC};
      5:  return {r[31:20], rs1, de_pkg::F3_LW, rd, de_pkg::OPC_LOAD};
      6:  return {r[31:25], rs2, rs1, de_pkg::F3_SW, r[11:7], de_pkg::OPC_STORE};
      7:  return {r[31:12], rd, de_pkg::OPC_JAL};
      8:  return {r[31:20], rs1, de_pkg::F3_JALR, rd, de_pkg::OPC_JALR};
      9:  return {r[31:25], rs2, rs1, r[14:12], r[11:7], de_pkg::OPC_BRANCH};
      10: return {r[31:20], rs1, r[0] ? de_pkg::F3_CSRRS : de_pkg::F3_CSRRW, rd,
                  de_pkg::OPC_SYSTEM};
      default: return r;  // mostly unknown encodings
    endcase
  endfunction

  // one falling edge: note reservations, drive writeback and misprediction
  task automatic next_cycle();
    @(negedge clk);
    cycle++;
    if (de_out.valid && de_out.wr_reg) begin
      pend_reg.push_back(de_out.rd);
      pend_due.push_back(cycle + int'($urandom % 6));
    end
    wb = '0;
    if (pend_reg.size() > 0 && pend_due[0] <= cycle) begin
      wb.wr_reg = 1'b1;
      wb.wregno = pend_reg.pop_front();
      wb.regval = $urandom;
      void'(pend_due.pop_front());
    end else if ($urandom % 16 == 0) begin
      wb.wr_reg = 1'b1;  // stray write to x0, dropped by the register file
      wb.regval = $urandom;
    end
    br_mispred = int'($urandom % 100) < mispred_pct;
  endtask

  task automatic offer(input logic [31:0] inst);
    int waits;
    waits          = 0;
    fe_latch.valid = 1'b1;
    fe_latch.inst  = inst;
    fe_latch.pc    = pc;
    fe_latch.pcplus = pc + 32'd4;
    next_cycle();
    while (last_stall) begin  // fetch holds the instruction
      waits++;
      if (waits > STALL_LIMIT) begin
        $display("timeout: instruction %h stalled for more than %0d cycles", inst, STALL_LIMIT);
        $display("Simulation failed");
        $finish;
      end
      next_cycle();
    end
    pc = pc + 32'd4;
  endtask

  task automatic run_test(input string name, input int count, input int span, input int pct);
    int err0;
    int chk0;
    i_checker.test_name = name;
    err0        = i_checker.errors;
    chk0        = i_checker.checks;
    mispred_pct = pct;
    for (int n = 0; n < count; n++) begin
      if ($urandom % 8 == 0) begin
        fe_latch      = '0;  // a cycle with nothing offered
        fe_latch.inst = random_inst(span);  // stale word, not valid
        next_cycle();
      end
      offer(random_inst(span));
    end
    $display("test %s: %0d checks, %0d errors", name, i_checker.checks - chk0,
             i_checker.errors - err0);
  endtask

  //////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////

  initial begin
    int waits;
    void'($urandom(32'hc0c2_9184));
    reset      = 1'b1;
    fe_latch   = '0;
    wb         = '0;
    br_mispred = 1'b0;
    i_checker.test_name = "reset";
    repeat (10) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    repeat (3) next_cycle();
    $display("test reset: %0d checks, %0d errors", i_checker.checks, i_checker.errors);

    run_test("random_mix", 300, 8, 5);
    run_test("hazard_chain", 200, 3, 0);
    run_test("mispredict", 150, 8, 30);
    run_test("x0_heavy", 150, 2, 5);

    // let writeback retire what is left
    fe_latch    = '0;
    mispred_pct = 0;
    waits       = 0;
    while (pend_reg.size() > 0) begin
      waits++;
      if (waits > DRAIN_LIMIT) begin
        $display("timeout: writeback queue did not drain");
        $display("Simulation failed");
        $finish;
      end
      next_cycle();
    end
    repeat (2) next_cycle();

    $display("all tests: %0d checks, %0d errors", i_checker.checks, i_checker.errors);
    if (i_checker.errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: dv/decode_checker.sv
`default_nettype none

module decode_checker (
  input wire logic              clk,
  input wire logic              reset,
  input wire de_pkg::fe_latch_t fe_latch,
  input wire de_pkg::wb_write_t wb,
  input wire logic              br_mispred,
  input wire logic              stall,
  input wire de_pkg::de_latch_t de_out
);

  timeunit 1ns;
  timeprecision 1ps;

  string test_name = "none";  // set by the testbench
  int    checks    = 0;
  int    errors    = 0;

  logic [de_pkg::DBITS-1:0]    model_regs [de_pkg::REGWORDS];
  logic [de_pkg::REGWORDS-1:0] model_busy;
  de_pkg::de_latch_t           exp_de;
  logic                        armed = 1'b0;  // model valid after the first reset edge

  //////////////////////////////////////////////////
  // decode table
  //////////////////////////////////////////////////

  function automatic de_pkg::decode_info_t model_decode(input logic [31:0] inst,
                                                        input logic valid);
    de_pkg::decode_info_t d;
    logic [6:0]           opc;
    logic [2:0]           f3;
    logic [6:0]           f7;
    logic                 r_fmt;
    logic                 writes;
    de_pkg::imm_type_e    fmt;
    opc    = inst[6:0];
    f3     = inst[14:12];
    f7     = inst[31:25];
    d      = '0;
    d.op   = de_pkg::IOP_INVALID;
    r_fmt  = 1'b0;
    fmt    = de_pkg::IMM_NONE;
    writes = 1'b1;
    if (opc == de_pkg::OPC_OP) begin
      r_fmt = 1'b1;
      if (f7 == de_pkg::F7_MUL && f3 == de_pkg::F3_MUL) d.op = de_pkg::IOP_MUL;
      else if (f7 == de_pkg::F7_SUB_SRA && f3 == de_pkg::F3_ADD) d.op = de_pkg::IOP_SUB;
      else if (f7 == de_pkg::F7_SUB_SRA && f3 == de_pkg::F3_SR) d.op = de_pkg::IOP_SRA;
      else if (f7 == de_pkg::F7_ZERO) begin
        case (f3)
          de_pkg::F3_ADD:  d.op = de_pkg::IOP_ADD;
          de_pkg::F3_SLL:  d.op = de_pkg::IOP_SLL;
          de_pkg::F3_SLT:  d.op = de_pkg::IOP_SLT;
          de_pkg::F3_SLTU: d.op = de_pkg::IOP_SLTU;
          de_pkg::F3_XOR:  d.op = de_pkg::IOP_XOR;
          de_pkg::F3_SR:   d.op = de_pkg::IOP_SRL;
          de_pkg::F3_OR:   d.op = de_pkg::IOP_OR;
          default:         d.op = de_pkg::IOP_AND;
        endcase
      end
    end else if (opc == de_pkg::OPC_OP_IMM) begin
      fmt = de_pkg::IMM_I;
      case (f3)
        de_pkg::F3_ADD:  d.op = de_pkg::IOP_ADDI;
        de_pkg::F3_SLT:  d.op = de_pkg::IOP_SLTI;
        de_pkg::F3_SLTU: d.op = de_pkg::IOP_SLTIU;
        de_pkg::F3_XOR:  d.op = de_pkg::IOP_XORI;
        de_pkg::F3_OR:   d.op = de_pkg::IOP_ORI;
        de_pkg::F3_AND:  d.op = de_pkg::IOP_ANDI;
        de_pkg::F3_SLL:  if (f7 == de_pkg::F7_ZERO) d.op = de_pkg::IOP_SLLI;
        default: begin  // shift right, funct7 picks the kind
          if (f7 == de_pkg::F7_ZERO) d.op = de_pkg::IOP_SRLI;
          if (f7 == de_pkg::F7_SUB_SRA) d.op = de_pkg::IOP_SRAI;
        end
      endcase
    end else if (opc == de_pkg::OPC_LUI || opc == de_pkg::OPC_AUIPC) begin
      fmt  = de_pkg::IMM_U;
      d.op = (opc == de_pkg::OPC_LUI) ? de_pkg::IOP_LUI : de_pkg::IOP_AUIPC;
    end else if (opc == de_pkg::OPC_JAL) begin
      fmt  = de_pkg::IMM_J;
      d.op = de_pkg::IOP_JAL;
    end else if (opc == de_pkg::OPC_JALR && f3 == de_pkg::F3_JALR) begin
      fmt  = de_pkg::IMM_I;
      d.op = de_pkg::IOP_JALR;
    end else if (opc == de_pkg::OPC_LOAD && f3 == de_pkg::F3_LW) begin
      fmt  = de_pkg::IMM_I;
      d.op = de_pkg::IOP_LW;
    end else if (opc == de_pkg::OPC_STORE && f3 == de_pkg::F3_SW) begin
      fmt    = de_pkg::IMM_S;
      d.op   = de_pkg::IOP_SW;
      writes = 1'b0;
    end else if (opc == de_pkg::OPC_BRANCH && f3 != 3'b010 && f3 != 3'b011) begin
      fmt    = de_pkg::IMM_B;
      writes = 1'b0;
      case (f3)
        de_pkg::F3_BEQ:  d.op = de_pkg::IOP_BEQ;
        de_pkg::F3_BNE:  d.op = de_pkg::IOP_BNE;
        de_pkg::F3_BLT:  d.op = de_pkg::IOP_BLT;
        de_pkg::F3_BGE:  d.op = de_pkg::IOP_BGE;
        de_pkg::F3_BLTU: d.op = de_pkg::IOP_BLTU;
        default:         d.op = de_pkg::IOP_BGEU;
      endcase
    end else if (opc == de_pkg::OPC_SYSTEM) begin
      if (f3 == de_pkg::F3_CSRRS) d.op = de_pkg::IOP_CSRR;
      if (f3 == de_pkg::F3_CSRRW) d.op = de_pkg::IOP_CSRW;
      fmt    = de_pkg::IMM_I;
      writes = (f3 == de_pkg::F3_CSRRS);
    end
    if (d.op == de_pkg::IOP_INVALID) begin  // unknown: no format, no flags
      r_fmt  = 1'b0;
      fmt    = de_pkg::IMM_NONE;
      writes = 1'b0;
    end
    case (fmt)
      de_pkg::IMM_I: d.imm = {{20{inst[31]}}, inst[31:20]};
      de_pkg::IMM_S: d.imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
      de_pkg::IMM_B: d.imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
      de_pkg::IMM_U: d.imm = {inst[31:12], 12'h000};
      de_pkg::IMM_J: d.imm = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21],
                              1'b0};
      default:       d.imm = '0;
    endcase
    d.is_br   = (fmt == de_pkg::IMM_B);
    d.is_jmp  = (d.op == de_pkg::IOP_JAL || d.op == de_pkg::IOP_JALR);
    d.rd_mem  = (d.op == de_pkg::IOP_LW);
    d.wr_mem  = (d.op == de_pkg::IOP_SW);
    d.wr_reg  = writes && valid && (inst[11:7] != 5'd0);
    d.use_rs1 = r_fmt || fmt == de_pkg::IMM_I || fmt == de_pkg::IMM_S || fmt == de_pkg::IMM_B;
    d.use_rs2 = r_fmt || fmt == de_pkg::IMM_S || fmt == de_pkg::IMM_B;
    d.rs1     = inst[19:15];
    d.rs2     = inst[24:20];
    d.rd      = inst[11:7];
    return d;
  endfunction

  //////////////////////////////////////////////////
  // model state and comparison
  //////////////////////////////////////////////////

  always @(posedge clk) begin
    de_pkg::decode_info_t d;
    logic                 exp_stall;
    d = model_decode(fe_latch.inst, fe_latch.valid);
    if (reset) begin
      for (int i = 0; i < de_pkg::REGWORDS; i++) model_regs[i] = '0;
      model_busy = '0;
      exp_de     = '0;
      armed      = 1'b1;
    end else if (armed) begin
      exp_stall = br_mispred || (fe_latch.valid &&
                  ((d.use_rs1 && model_busy[d.rs1]) || (d.use_rs2 && model_busy[d.rs2])));
      checks++;
      if (stall !== exp_stall) begin
        errors++;
        $display("error %s: stall expected %0b actual %0b", test_name, exp_stall, stall);
      end
      exp_de = '0;
      if (!exp_stall) begin
        exp_de.valid   = fe_latch.valid;
        exp_de.inst    = fe_latch.inst;
        exp_de.pc      = fe_latch.pc;
        exp_de.pcplus  = fe_latch.pcplus;
        exp_de.op      = d.op;
        exp_de.rs1_val = model_regs[d.rs1];
        exp_de.rs2_val = model_regs[d.rs2];
        exp_de.imm     = d.imm;
        exp_de.is_br   = d.is_br;
        exp_de.is_jmp  = d.is_jmp;
        exp_de.rd_mem  = d.rd_mem;
        exp_de.wr_mem  = d.wr_mem;
        exp_de.wr_reg  = d.wr_reg;
        exp_de.rd      = d.rd;
        if (fe_latch.valid && d.wr_reg) model_busy[d.rd] = 1'b1;
      end
      if (wb.wr_reg) begin
        model_busy[wb.wregno] = 1'b0;  // clear after set, so it wins
        if (wb.wregno != 5'd0) model_regs[wb.wregno] = wb.regval;
      end
    end
  end

  // de_out settles after the edge, compare half a cycle later
  always @(negedge clk) begin
    if (armed) begin
      checks++;
      if (de_out !== exp_de) begin
        errors++;
        $display("error %s: de_out expected %h actual %h", test_name, exp_de, de_out);
      end
    end
  end

endmodule

`default_nettype wire

// File: dv/decode_stage_assert.sv
`default_nettype none

module decode_stage_assert (
  input wire logic              clk,
  input wire logic              reset,
  input wire logic              stall,
  input wire logic              issue,
  input wire logic              valid,
  input wire de_pkg::de_latch_t de_out
);

  timeunit 1ns;
  timeprecision 1ps;

  a_stall_blocks_issue: assert property (@(posedge clk) disable iff (reset) stall |-> !issue)
    else $error("issue raised while the stage is stalled");

  // a stalled cycle leaves a bubble behind
  a_bubble_after_stall: assert property (@(posedge clk) disable iff (reset)
    stall |=> (de_out == '0))
    else $error("de_out not cleared in the cycle after a stall");

  a_issue_needs_valid: assert property (@(posedge clk) disable iff (reset) issue |-> valid)
    else $error("issue raised without a valid instruction");

  a_reset_clears_latch: assert property (@(posedge clk) reset |=> (de_out == '0))
    else $error("de_out not cleared after reset");

endmodule

`default_nettype wire

// File: hw/decode_stage.sv
`default_nettype none

module decode_stage (
  input  wire logic                  clk,
  input  wire logic                  reset,
  input  wire de_pkg::fe_latch_t     fe_latch,
  input  wire de_pkg::wb_write_t     wb,
  input  wire logic                  br_mispred,  // level from execute
  output logic                       stall,       // holds fetch
  output de_pkg::de_latch_t          de_out
);

  de_pkg::decode_info_t     info;
  logic [de_pkg::DBITS-1:0] rs1_val;
  logic [de_pkg::DBITS-1:0] rs2_val;
  logic                     hazard;
  logic                     issue;

  instr_decoder i_instr_decoder (
    .inst  (fe_latch.inst),
    .valid (fe_latch.valid),
    .info  (info)
  );

  reg_scoreboard i_reg_scoreboard (
    .clk     (clk),
    .reset   (reset),
    .info    (info),
    .wb      (wb),
    .issue   (issue),
    .rs1_val (rs1_val),
    .rs2_val (rs2_val),
    .hazard  (hazard)
  );

  de_latch_stage i_de_latch_stage (
    .clk        (clk),
    .reset      (reset),
    .fe_latch   (fe_latch),
    .info       (info),
    .rs1_val    (rs1_val),
    .rs2_val    (rs2_val),
    .hazard     (hazard),
    .br_mispred (br_mispred),
    .stall      (stall),
    .issue      (issue),
    .de_out     (de_out)
  );

endmodule

`default_nettype wire

// File: hw/de_latch_stage.sv
`default_nettype none

module de_latch_stage (
  input  wire logic                      clk,
  input  wire logic                      reset,
  input  wire de_pkg::fe_latch_t         fe_latch,
  input  wire de_pkg::decode_info_t      info,
  input  wire logic [de_pkg::DBITS-1:0]  rs1_val,
  input  wire logic [de_pkg::DBITS-1:0]  rs2_val,
  input  wire logic                      hazard,
  input  wire logic                      br_mispred,
  output logic                           stall,
  output logic                           issue,
  output de_pkg::de_latch_t              de_out
);

  de_pkg::de_latch_t next_latch;

  assign stall = br_mispred || (fe_latch.valid && hazard);
  assign issue = fe_latch.valid && !stall;  // reserves rd in the scoreboard

  always_comb begin
    next_latch.valid   = fe_latch.valid;
    next_latch.inst    = fe_latch.inst;
    next_latch.pc      = fe_latch.pc;
    next_latch.pcplus  = fe_latch.pcplus;
    next_latch.op      = info.op;
    next_latch.rs1_val = rs1_val;
    next_latch.rs2_val = rs2_val;
    next_latch.imm     = info.imm;
    next_latch.is_br   = info.is_br;
    next_latch.is_jmp  = info.is_jmp;
    next_latch.rd_mem  = info.rd_mem;
    next_latch.wr_mem  = info.wr_mem;
    next_latch.wr_reg  = info.wr_reg;
    next_latch.rd      = info.rd;
  end

  //////////////////////////////////////////////////
  // output latch
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset || stall) begin
      de_out <= '0;  // bubble
    end else begin
      de_out <= next_latch;
    end
  end

endmodule

`default_nettype wire

// File: hw/reg_scoreboard.sv
`default_nettype none

module reg_scoreboard (
  input  wire logic                      clk,
  input  wire logic                      reset,
  input  wire de_pkg::decode_info_t      info,
  input  wire de_pkg::wb_write_t         wb,
  input  wire logic                      issue,
  output logic [de_pkg::DBITS-1:0]       rs1_val,
  output logic [de_pkg::DBITS-1:0]       rs2_val,
  output logic                           hazard
);

  logic [de_pkg::DBITS-1:0]    regs [de_pkg::REGWORDS];
  logic [de_pkg::REGWORDS-1:0] in_use;  // one bit per register

  //////////////////////////////////////////////////
  // register file
  //////////////////////////////////////////////////

  // reads are combinational, a register under writeback still reads old data
  assign rs1_val = regs[info.rs1];
  assign rs2_val = regs[info.rs2];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < de_pkg::REGWORDS; i++) begin
        regs[i] <= '0;
      end
    end else if (wb.wr_reg && (wb.wregno != '0)) begin  // x0 stays zero
      regs[wb.wregno] <= wb.regval;
    end
  end

  //////////////////////////////////////////////////
  // in-use bits
  //////////////////////////////////////////////////

  // the writeback clear is last, so it wins over a reservation of the same register
  always_ff @(posedge clk) begin
    if (reset) begin
      in_use <= '0;
    end else begin
      if (issue && info.wr_reg) begin
        in_use[info.rd] <= 1'b1;
      end
      if (wb.wr_reg) begin
        in_use[wb.wregno] <= 1'b0;
      end
    end
  end

  assign hazard = (info.use_rs1 && in_use[info.rs1])
               || (info.use_rs2 && in_use[info.rs2]);

endmodule

`default_nettype wire

// File: hw/instr_decoder.sv
`default_nettype none

module instr_decoder (
  input  wire logic [de_pkg::INSTBITS-1:0] inst,
  input  wire logic                        valid,
  output de_pkg::decode_info_t             info
);

  de_pkg::opcode_e   opc;
  logic [2:0]        f3;
  logic [6:0]        f7;
  de_pkg::iop_e      iop;
  de_pkg::imm_type_e imm_type;
  logic              is_r;       // register-register format
  logic              writes_rd;  // opcode has a destination
  logic [de_pkg::DBITS-1:0] imm;

  assign opc = de_pkg::opcode_e'(inst[6:0]);
  assign f3  = inst[14:12];
  assign f7  = inst[31:25];

  //////////////////////////////////////////////////
  // opcode match
  //////////////////////////////////////////////////

  always_comb begin
    iop = de_pkg::IOP_INVALID;  // anything unmatched
    case (opc)
      de_pkg::OPC_OP: begin
        case ({f7, f3})
          {de_pkg::F7_ZERO,    de_pkg::F3_ADD}:  iop = de_pkg::IOP_ADD;
          {de_pkg::F7_SUB_SRA, de_pkg::F3_ADD}:  iop = de_pkg::IOP_SUB;
          {de_pkg::F7_ZERO,    de_pkg::F3_AND}:  iop = de_pkg::IOP_AND;
          {de_pkg::F7_ZERO,    de_pkg::F3_OR}:   iop = de_pkg::IOP_OR;
          {de_pkg::F7_ZERO,    de_pkg::F3_XOR}:  iop = de_pkg::IOP_XOR;
          {de_pkg::F7_ZERO,    de_pkg::F3_SLT}:  iop = de_pkg::IOP_SLT;
          {de_pkg::F7_ZERO,    de_pkg::F3_SLTU}: iop = de_pkg::IOP_SLTU;
          {de_pkg::F7_SUB_SRA, de_pkg::F3_SR}:   iop = de_pkg::IOP_SRA;
          {de_pkg::F7_ZERO,    de_pkg::F3_SR}:   iop = de_pkg::IOP_SRL;
          {de_pkg::F7_ZERO,    de_pkg::F3_SLL}:  iop = de_pkg::IOP_SLL;
          {de_pkg::F7_MUL,     de_pkg::F3_MUL}:  iop = de_pkg::IOP_MUL;
          default: ;
        endcase
      end
      de_pkg::OPC_OP_IMM: begin
        case (f3)
          de_pkg::F3_ADD:  iop = de_pkg::IOP_ADDI;
          de_pkg::F3_AND:  iop = de_pkg::IOP_ANDI;
          de_pkg::F3_OR:   iop = de_pkg::IOP_ORI;
          de_pkg::F3_XOR:  iop = de_pkg::IOP_XORI;
          de_pkg::F3_SLT:  iop = de_pkg::IOP_SLTI;
          de_pkg::F3_SLTU: iop = de_pkg::IOP_SLTIU;
          de_pkg::F3_SLL:  if (f7 == de_pkg::F7_ZERO) iop = de_pkg::IOP_SLLI;
          de_pkg::F3_SR: begin
            if (f7 == de_pkg::F7_ZERO)         iop = de_pkg::IOP_SRLI;
            else if (f7 == de_pkg::F7_SUB_SRA) iop = de_pkg::IOP_SRAI;
          end
          default: ;
        endcase
      end
      de_pkg::OPC_LUI:   iop = de_pkg::IOP_LUI;
      de_pkg::OPC_AUIPC: iop = de_pkg::IOP_AUIPC;
      de_pkg::OPC_JAL:   iop = de_pkg::IOP_JAL;
      de_pkg::OPC_LOAD:  if (f3 == de_pkg::F3_LW)   iop = de_pkg::IOP_LW;
      de_pkg::OPC_STORE: if (f3 == de_pkg::F3_SW)   iop = de_pkg::IOP_SW;
      de_pkg::OPC_JALR:  if (f3 == de_pkg::F3_JALR) iop = de_pkg::IOP_JALR;
      de_pkg::OPC_BRANCH: begin
        case (f3)
          de_pkg::F3_BEQ:  iop = de_pkg::IOP_BEQ;
          de_pkg::F3_BNE:  iop = de_pkg::IOP_BNE;
          de_pkg::F3_BLT:  iop = de_pkg::IOP_BLT;
          de_pkg::F3_BGE:  iop = de_pkg::IOP_BGE;
          de_pkg::F3_BLTU: iop = de_pkg::IOP_BLTU;
          de_pkg::F3_BGEU: iop = de_pkg::IOP_BGEU;
          default: ;
        endcase
      end
      de_pkg::OPC_SYSTEM: begin
        if (f3 == de_pkg::F3_CSRRS)      iop = de_pkg::IOP_CSRR;
        else if (f3 == de_pkg::F3_CSRRW) iop = de_pkg::IOP_CSRW;
      end
      default: ;
    endcase
  end

  // format and destination, from the internal opcode
  always_comb begin
    imm_type  = de_pkg::IMM_NONE;
    is_r      = 1'b0;
    writes_rd = 1'b0;
    case (iop)
      de_pkg::IOP_ADD, de_pkg::IOP_SUB, de_pkg::IOP_AND, de_pkg::IOP_OR,
      de_pkg::IOP_XOR, de_pkg::IOP_SLT, de_pkg::IOP_SLTU, de_pkg::IOP_SRA,
      de_pkg::IOP_SRL, de_pkg::IOP_SLL, de_pkg::IOP_MUL: begin
        is_r      = 1'b1;
        writes_rd = 1'b1;
      end
      de_pkg::IOP_ADDI, de_pkg::IOP_ANDI, de_pkg::IOP_ORI, de_pkg::IOP_XORI,
      de_pkg::IOP_SLTI, de_pkg::IOP_SLTIU, de_pkg::IOP_SRAI, de_pkg::IOP_SRLI,
      de_pkg::IOP_SLLI, de_pkg::IOP_LW, de_pkg::IOP_JALR, de_pkg::IOP_CSRR: begin
        imm_type  = de_pkg::IMM_I;
        writes_rd = 1'b1;
      end
      de_pkg::IOP_CSRW: imm_type = de_pkg::IMM_I;  // no destination
      de_pkg::IOP_LUI, de_pkg::IOP_AUIPC: begin
        imm_type  = de_pkg::IMM_U;
        writes_rd = 1'b1;
      end
      de_pkg::IOP_JAL: begin
        imm_type  = de_pkg::IMM_J;
        writes_rd = 1'b1;
      end
      de_pkg::IOP_SW: imm_type = de_pkg::IMM_S;
      de_pkg::IOP_BEQ, de_pkg::IOP_BNE, de_pkg::IOP_BLT, de_pkg::IOP_BGE,
      de_pkg::IOP_BLTU, de_pkg::IOP_BGEU: imm_type = de_pkg::IMM_B;
      default: ;
    endcase
  end

  // sign-extended immediate
  always_comb begin
    case (imm_type)
      de_pkg::IMM_I: imm = {{21{inst[31]}}, inst[30:20]};
      de_pkg::IMM_S: imm = {{21{inst[31]}}, inst[30:25], inst[11:7]};
      de_pkg::IMM_B: imm = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
      de_pkg::IMM_U: imm = {inst[31:12], 12'b0};
      de_pkg::IMM_J: imm = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
      default:       imm = '0;
    endcase
  end

  always_comb begin
    info.op      = iop;
    info.imm     = imm;
    info.is_br   = (imm_type == de_pkg::IMM_B);
    info.is_jmp  = (iop == de_pkg::IOP_JAL) || (iop == de_pkg::IOP_JALR);
    info.rd_mem  = (iop == de_pkg::IOP_LW);
    info.wr_mem  = (iop == de_pkg::IOP_SW);
    info.wr_reg  = writes_rd && (inst[11:7] != '0) && valid;  // x0 never reserved
    info.use_rs1 = is_r || (imm_type inside {de_pkg::IMM_I, de_pkg::IMM_S, de_pkg::IMM_B});
    info.use_rs2 = is_r || (imm_type inside {de_pkg::IMM_S, de_pkg::IMM_B});
    info.rs1     = inst[19:15];
    info.rs2     = inst[24:20];
    info.rd      = inst[11:7];
  end

endmodule

`default_nettype wire

// File: hw/de_pkg.sv
`default_nettype none

package de_pkg;

  //////////////////////////////////////////////////
  // widths
  //////////////////////////////////////////////////

  localparam int DBITS     = 32;  // data word
  localparam int INSTBITS  = 32;  // instruction word
  localparam int REGNOBITS = 5;   // register number
  localparam int REGWORDS  = 32;  // architectural registers
  localparam int IOPBITS   = 6;   // internal opcode

  //////////////////////////////////////////////////
  // encodings
  //////////////////////////////////////////////////

  // major opcodes, inst[6:0]
  typedef enum logic [6:0] {
    OPC_OP     = 7'b0110011,
    OPC_OP_IMM = 7'b0010011,
    OPC_LUI    = 7'b0110111,
    OPC_AUIPC  = 7'b0010111,
    OPC_LOAD   = 7'b0000011,
    OPC_STORE  = 7'b0100011,
    OPC_JAL    = 7'b1101111,
    OPC_JALR   = 7'b1100111,
    OPC_BRANCH = 7'b1100011,
    OPC_SYSTEM = 7'b1110011
  } opcode_e;

  // funct7, inst[31:25]
  localparam logic [6:0] F7_ZERO    = 7'b0000000;
  localparam logic [6:0] F7_SUB_SRA = 7'b0100000;  // also srai
  localparam logic [6:0] F7_MUL     = 7'b0000001;

  // funct3 for alu ops, inst[14:12]
  localparam logic [2:0] F3_ADD  = 3'b000;  // add, sub, addi
  localparam logic [2:0] F3_SLL  = 3'b001;
  localparam logic [2:0] F3_SLT  = 3'b010;
  localparam logic [2:0] F3_SLTU = 3'b011;
  localparam logic [2:0] F3_XOR  = 3'b100;
  localparam logic [2:0] F3_SR   = 3'b101;  // srl, sra and the immediates
  localparam logic [2:0] F3_OR   = 3'b110;
  localparam logic [2:0] F3_AND  = 3'b111;
  localparam logic [2:0] F3_MUL  = 3'b000;

  // funct3 for memory, jump and csr
  localparam logic [2:0] F3_LW    = 3'b010;
  localparam logic [2:0] F3_SW    = 3'b010;
  localparam logic [2:0] F3_JALR  = 3'b000;
  localparam logic [2:0] F3_CSRRW = 3'b001;  // csrw
  localparam logic [2:0] F3_CSRRS = 3'b010;  // csrr

  // funct3 for branches
  localparam logic [2:0] F3_BEQ  = 3'b000;
  localparam logic [2:0] F3_BNE  = 3'b001;
  localparam logic [2:0] F3_BLT  = 3'b100;
  localparam logic [2:0] F3_BGE  = 3'b101;
  localparam logic [2:0] F3_BLTU = 3'b110;
  localparam logic [2:0] F3_BGEU = 3'b111;

  // internal opcodes
  typedef enum logic [IOPBITS-1:0] {
    IOP_ADD, IOP_SUB, IOP_AND, IOP_OR, IOP_XOR, IOP_SLT, IOP_SLTU,
    IOP_SRA, IOP_SRL, IOP_SLL, IOP_MUL,
    IOP_ADDI, IOP_ANDI, IOP_ORI, IOP_XORI, IOP_SLTI, IOP_SLTIU,
    IOP_SRAI, IOP_SRLI, IOP_SLLI,
    IOP_LUI, IOP_AUIPC, IOP_LW, IOP_SW, IOP_JAL, IOP_JALR,
    IOP_BEQ, IOP_BNE, IOP_BLT, IOP_BGE, IOP_BLTU, IOP_BGEU,
    IOP_CSRR, IOP_CSRW,
    IOP_INVALID
  } iop_e;

  typedef enum logic [2:0] {
    IMM_NONE, IMM_I, IMM_S, IMM_B, IMM_U, IMM_J
  } imm_type_e;

  //////////////////////////////////////////////////
  // stage records
  //////////////////////////////////////////////////

  typedef struct packed {
    logic                valid;
    logic [INSTBITS-1:0] inst;
    logic [DBITS-1:0]    pc;
    logic [DBITS-1:0]    pcplus;
  } fe_latch_t;

  typedef struct packed {
    logic                 wr_reg;  // one-cycle strobe
    logic [REGNOBITS-1:0] wregno;
    logic [DBITS-1:0]     regval;
  } wb_write_t;

  typedef struct packed {
    iop_e                 op;
    logic [DBITS-1:0]     imm;
    logic                 is_br;
    logic                 is_jmp;
    logic                 rd_mem;
    logic                 wr_mem;
    logic                 wr_reg;
    logic                 use_rs1;
    logic                 use_rs2;
    logic [REGNOBITS-1:0] rs1;
    logic [REGNOBITS-1:0] rs2;
    logic [REGNOBITS-1:0] rd;
  } decode_info_t;

  typedef struct packed {
    logic                 valid;
    logic [INSTBITS-1:0]  inst;
    logic [DBITS-1:0]     pc;
    logic [DBITS-1:0]     pcplus;
    iop_e                 op;
    logic [DBITS-1:0]     rs1_val;
    logic [DBITS-1:0]     rs2_val;
    logic [DBITS-1:0]     imm;
    logic                 is_br;
    logic                 is_jmp;
    logic                 rd_mem;
    logic                 wr_mem;
    logic                 wr_reg;
    logic [REGNOBITS-1:0] rd;
  } de_latch_t;

endpackage

`default_nettype wire
